//--- hdl/rv_exec_config.svh
//----------------------------------------------------------
// RV32I execute stage sizing
// data word width and shift amount width
//----------------------------------------------------------
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// shift amount is log2 of the word width
`define RV_XLEN     32
`define RV_SHAMT_W  5

`endif

//--- hdl/rv_exec_pkg.sv
//----------------------------------------------------------
// RV32I execute stage types
// data word, ALU operations, compare conditions, opcodes
//----------------------------------------------------------
`default_nettype none

`include "rv_exec_config.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_MOV  = 4'd10
    } alu_op_e;

    // encodings follow branch funct3, NONE sits in an unused slot
    typedef enum logic [2:0] {
        CMP_EQ   = 3'b000,
        CMP_NE   = 3'b001,
        CMP_NONE = 3'b010,
        CMP_LT   = 3'b100,
        CMP_GE   = 3'b101,
        CMP_LTU  = 3'b110,
        CMP_GEU  = 3'b111
    } alu_cond_e;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011
    } rv_opcode_e;

endpackage

`default_nettype wire

//--- hdl/rv_alu_if.sv
//----------------------------------------------------------
// decoder to ALU bundle
// operands, operation, compare condition and clock enable
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface rv_alu_if;
    import rv_exec_pkg::*;

    // arithmetic path
    xlen_t     op_left;
    xlen_t     op_right;
    alu_op_e   op_opcode;
    // branch compare path
    xlen_t     cmp_left;
    xlen_t     cmp_right;
    alu_cond_e cmp_opcode;
    // shared pipeline advance
    logic      clk_en;

    modport decoder (
        output op_left, op_right, op_opcode,
        output cmp_left, cmp_right, cmp_opcode,
        output clk_en
    );

    modport alu (
        input op_left, op_right, op_opcode,
        input cmp_left, cmp_right, cmp_opcode,
        input clk_en
    );
endinterface

`default_nettype wire

//--- hdl/rv_decode.sv
//----------------------------------------------------------
// RV32I execute decoder
// picks ALU operation, condition and operands, registers side-band
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  logic [31:0]        instr_i,
    input  rv_exec_pkg::xlen_t pc_i,
    input  rv_exec_pkg::xlen_t rs1_data_i,
    input  rv_exec_pkg::xlen_t rs2_data_i,
    rv_alu_if.decoder          alu_o,
    output logic               valid_o,
    output logic [4:0]         rd_o,
    output logic               wr_en_o,
    output logic               illegal_o
);
    import rv_exec_pkg::*;

    rv_opcode_e opcode;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    logic       legal;
    logic       writes_rd;
    logic       clk_en;

    // shared funct3 table for OP and OP-IMM
    function automatic alu_op_e funct3_to_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    //----------------------------------------------------------
    // field extraction
    //----------------------------------------------------------
    assign opcode = rv_opcode_e'(instr_i[6:0]);
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = xlen_t'($signed(instr_i[31:20]));
    assign imm_u = xlen_t'($signed({instr_i[31:12], 12'h000}));
    assign imm_b = xlen_t'($signed({instr_i[31], instr_i[7], instr_i[30:25],
                                    instr_i[11:8], 1'b0}));

    assign clk_en       = ~stall_i;
    assign alu_o.clk_en = clk_en;

    //----------------------------------------------------------
    // operation and operand select
    //----------------------------------------------------------
    always_comb begin
        alu_o.op_left    = rs1_data_i;
        alu_o.op_right   = rs2_data_i;
        alu_o.op_opcode  = ALU_ADD;
        alu_o.cmp_left   = rs1_data_i;
        alu_o.cmp_right  = rs2_data_i;
        alu_o.cmp_opcode = CMP_NONE;
        legal            = 1'b1;
        writes_rd        = 1'b1;
        case (opcode)
            OPC_OP: begin
                alu_o.op_opcode = funct3_to_op(funct3, funct7[5]);
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                alu_o.op_right  = imm_i;
                // only srai uses the alternate bit
                alu_o.op_opcode = funct3_to_op(funct3, (funct3 == 3'b101) & instr_i[30]);
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            OPC_LUI: begin
                alu_o.op_opcode = ALU_MOV;
                alu_o.op_right  = imm_u;
            end
            OPC_AUIPC: begin
                alu_o.op_left  = pc_i;
                alu_o.op_right = imm_u;
            end
            OPC_BRANCH: begin
                // result is the branch target
                alu_o.op_left  = pc_i;
                alu_o.op_right = imm_b;
                writes_rd      = 1'b0;
                legal          = (funct3[2:1] != 2'b01);
                if (valid_i && legal) begin
                    alu_o.cmp_opcode = alu_cond_e'(funct3);
                end
            end
            default: begin
                legal     = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
    end

    //----------------------------------------------------------
    // side-band registers, aligned with the ALU
    //----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            rd_o      <= 5'd0;
            wr_en_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else if (clk_en) begin
            valid_o   <= valid_i;
            rd_o      <= rd;
            wr_en_o   <= valid_i & legal & writes_rd & (rd != 5'd0);
            illegal_o <= valid_i & ~legal;
        end
    end
endmodule

`default_nettype wire

//--- hdl/rv_alu.sv
//----------------------------------------------------------
// RV32I ALU
// registered arithmetic, logic, shift and branch compare
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module rv_alu (
    input  logic               clk_i,
    input  logic               rst_n_i,
    rv_alu_if.alu              alu_i,
    output rv_exec_pkg::xlen_t op_result_o,
    output logic               cmp_result_o
);
    import rv_exec_pkg::*;

    xlen_t result_mux;
    xlen_t shl_val;
    xlen_t shr_val;
    logic  shr_fill;
    logic  op_lts;
    logic  op_ltu;
    logic  cmp_lts;
    logic  cmp_ltu;
    logic  cmp_hit;

    //----------------------------------------------------------
    // barrel shifter
    //----------------------------------------------------------
    // sign fill only for sra of a negative operand
    assign shr_fill = (alu_i.op_opcode == ALU_SRA) & alu_i.op_left[`RV_XLEN-1];

    // stage i shifts by 2**i when amount bit i is set
    always_comb begin
        shl_val = alu_i.op_left;
        shr_val = alu_i.op_left;
        for (int i = 0; i < `RV_SHAMT_W; i++) begin
            if (alu_i.op_right[i]) begin
                shl_val = shl_val << (2 ** i);
                shr_val = xlen_t'($signed({shr_fill, shr_val}) >>> (2 ** i));
            end
        end
    end

    //----------------------------------------------------------
    // comparators
    //----------------------------------------------------------
    // set-less-than works on the arithmetic operands
    assign op_lts  = $signed(alu_i.op_left) < $signed(alu_i.op_right);
    assign op_ltu  = alu_i.op_left < alu_i.op_right;
    // branches work on the compare operands
    assign cmp_lts = $signed(alu_i.cmp_left) < $signed(alu_i.cmp_right);
    assign cmp_ltu = alu_i.cmp_left < alu_i.cmp_right;

    always_comb begin
        case (alu_i.cmp_opcode)
            CMP_EQ:  cmp_hit = (alu_i.cmp_left == alu_i.cmp_right);
            CMP_NE:  cmp_hit = (alu_i.cmp_left != alu_i.cmp_right);
            CMP_LT:  cmp_hit = cmp_lts;
            CMP_GE:  cmp_hit = ~cmp_lts;
            CMP_LTU: cmp_hit = cmp_ltu;
            CMP_GEU: cmp_hit = ~cmp_ltu;
            default: cmp_hit = 1'b0;
        endcase
    end

    //----------------------------------------------------------
    // result select
    //----------------------------------------------------------
    always_comb begin
        case (alu_i.op_opcode)
            ALU_ADD:          result_mux = alu_i.op_left + alu_i.op_right;
            ALU_SUB:          result_mux = alu_i.op_left - alu_i.op_right;
            ALU_SLL:          result_mux = shl_val;
            ALU_SLT:          result_mux = xlen_t'(op_lts);
            ALU_SLTU:         result_mux = xlen_t'(op_ltu);
            ALU_XOR:          result_mux = alu_i.op_left ^ alu_i.op_right;
            ALU_SRL, ALU_SRA: result_mux = shr_val;
            ALU_OR:           result_mux = alu_i.op_left | alu_i.op_right;
            ALU_AND:          result_mux = alu_i.op_left & alu_i.op_right;
            ALU_MOV:          result_mux = alu_i.op_right;
            default:          result_mux = '0;
        endcase
    end

    // output registers advance with the decoder side-band
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_result_o  <= '0;
            cmp_result_o <= 1'b0;
        end else if (alu_i.clk_en) begin
            op_result_o  <= result_mux;
            cmp_result_o <= cmp_hit;
        end
    end
endmodule

`default_nettype wire

//--- hdl/rv_exec_stage.sv
//----------------------------------------------------------
// RV32I integer execute stage
// decoder plus ALU, one registered result per cycle
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rv_exec_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  logic [31:0]        instr_i,
    input  rv_exec_pkg::xlen_t pc_i,
    input  rv_exec_pkg::xlen_t rs1_data_i,
    input  rv_exec_pkg::xlen_t rs2_data_i,
    output logic               valid_o,
    output logic               wr_en_o,
    output logic               illegal_o,
    output logic               branch_taken_o,
    output logic [4:0]         rd_o,
    output rv_exec_pkg::xlen_t result_o
);

    // decoder to ALU bundle
    rv_alu_if alu_bus ();

    rv_decode u_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .valid_i    (valid_i),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .alu_o      (alu_bus.decoder),
        .valid_o    (valid_o),
        .rd_o       (rd_o),
        .wr_en_o    (wr_en_o),
        .illegal_o  (illegal_o)
    );

    rv_alu u_alu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .alu_i        (alu_bus.alu),
        .op_result_o  (result_o),
        .cmp_result_o (branch_taken_o)
    );
endmodule

`default_nettype wire

//--- dv/tb_rv_exec.sv
//----------------------------------------------------------
// testbench for the RV32I execute stage
// replays the data file and checks each registered result
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;
    import rv_exec_pkg::*;

    localparam int    CLK_PERIOD     = 20;
    localparam int    DRIVE_DELAY    = 2;
    localparam int    TIMEOUT_CYCLES = 50;
    localparam string DATA_FILE      = "dv/exec_input.txt";

    // one accepted instruction and what it should produce
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        xlen_t       result;
        logic        wr_en;
        logic        illegal;
        logic        taken;
        logic [4:0]  rd;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        valid;
    logic [31:0] instr;
    xlen_t       pc;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    logic        out_valid;
    logic        out_wr_en;
    logic        out_illegal;
    logic        out_taken;
    logic [4:0]  out_rd;
    xlen_t       out_result;

    expect_t     pending [$];
    logic        stalled_last;
    int          vectors_checked;

    // last item on the outputs, a stall must keep it there
    expect_t     held;

    rv_exec_stage u_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .stall_i        (stall),
        .valid_i        (valid),
        .instr_i        (instr),
        .pc_i           (pc),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .valid_o        (out_valid),
        .wr_en_o        (out_wr_en),
        .illegal_o      (out_illegal),
        .branch_taken_o (out_taken),
        .rd_o           (out_rd),
        .result_o       (out_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //----------------------------------------------------------
    // reporting and compare tasks
    //----------------------------------------------------------
    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("[FAIL] time %0t: %s mismatch, got 0x%0h expected 0x%0h",
                 $time, what, got, want);
        $display("test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string reason);
        $display("error at time %0t: %s", $time, reason);
        $display("test failed");
        $fatal(1, "simulation aborted");
    endtask

    task automatic check_result(input xlen_t exp_result, input logic [4:0] exp_rd);
        if (out_result !== exp_result) begin
            report_mismatch("result_o", out_result, exp_result);
        end
        if (out_rd !== exp_rd) begin
            report_mismatch("rd_o", 32'(out_rd), 32'(exp_rd));
        end
    endtask

    task automatic check_branch(input logic exp_taken, input xlen_t exp_target);
        if (out_taken !== exp_taken) begin
            report_mismatch("branch_taken_o", 32'(out_taken), 32'(exp_taken));
        end
        if (out_result !== exp_target) begin
            report_mismatch("branch target", out_result, exp_target);
        end
    endtask

    task automatic check_flags(input logic exp_valid, input logic exp_wr_en,
                               input logic exp_illegal, input logic exp_taken);
        if (out_valid !== exp_valid) begin
            report_mismatch("valid_o", 32'(out_valid), 32'(exp_valid));
        end
        if (out_wr_en !== exp_wr_en) begin
            report_mismatch("wr_en_o", 32'(out_wr_en), 32'(exp_wr_en));
        end
        if (out_illegal !== exp_illegal) begin
            report_mismatch("illegal_o", 32'(out_illegal), 32'(exp_illegal));
        end
        if (out_taken !== exp_taken) begin
            report_mismatch("branch_taken_o", 32'(out_taken), 32'(exp_taken));
        end
    endtask

    task automatic check_expected(input expect_t e);
        check_flags(e.valid, e.wr_en, e.illegal, e.taken);
        // bubbles and illegal words carry no result
        if (e.valid && !e.illegal) begin
            if (rv_opcode_e'(e.instr[6:0]) == OPC_BRANCH) begin
                check_branch(e.taken, e.result);
            end else begin
                check_result(e.result, e.rd);
            end
        end
    endtask

    // checks whatever the last edge was expected to produce
    task automatic compare_outputs();
        if (stalled_last) begin
            check_expected(held);
            vectors_checked++;
        end else if (pending.size() > 0) begin
            held = pending.pop_front();
            check_expected(held);
            vectors_checked++;
        end
    endtask

    //----------------------------------------------------------
    // main sequence
    //----------------------------------------------------------
    initial begin
        int          fd;
        int          n;
        int          cycles;
        string       line;
        logic        f_stall;
        logic        f_valid;
        logic [31:0] f_instr;
        xlen_t       f_pc;
        xlen_t       f_rs1;
        xlen_t       f_rs2;
        xlen_t       f_result;
        logic        f_wr_en;
        logic        f_illegal;
        logic        f_taken;
        logic [4:0]  f_rd;
        expect_t     e;

        clk             = 1'b0;
        rst_n           = 1'b0;
        stall           = 1'b0;
        valid           = 1'b0;
        instr           = '0;
        pc              = '0;
        rs1_data        = '0;
        rs2_data        = '0;
        stalled_last    = 1'b0;
        vectors_checked = 0;
        // idle outputs after reset
        held            = '0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus data file");
        end

        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        // everything cleared while reset is held
        check_flags(1'b0, 1'b0, 1'b0, 1'b0);
        check_result('0, 5'd0);
        rst_n = 1'b1;

        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run("reset was not released in time");
            end
        end while (rst_n !== 1'b1);

        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        f_stall, f_valid, f_instr, f_pc, f_rs1, f_rs2,
                        f_result, f_wr_en, f_illegal, f_taken, f_rd);
            if (n != 11) begin
                abort_run("malformed line in the stimulus data file");
            end

            @(posedge clk);
            #DRIVE_DELAY;
            compare_outputs();

            if (!f_stall) begin
                e = '{f_valid, f_instr, f_result, f_wr_en, f_illegal, f_taken, f_rd};
                pending.push_back(e);
            end
            stalled_last = f_stall;
            stall        = f_stall;
            valid        = f_valid;
            instr        = f_instr;
            pc           = f_pc;
            rs1_data     = f_rs1;
            rs2_data     = f_rs2;
        end
        $fclose(fd);

        // drain the last accepted item with idle inputs
        cycles = 0;
        while (pending.size() > 0 || stalled_last) begin
            @(posedge clk);
            #DRIVE_DELAY;
            compare_outputs();
            stalled_last = 1'b0;
            stall        = 1'b0;
            valid        = 1'b0;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run("results did not drain before the timeout");
            end
        end

        if (vectors_checked > 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("no data lines were found in %s", DATA_FILE);
            $display("test failed");
            $fatal(1, "empty stimulus");
        end
    end
endmodule

`default_nettype wire

//--- dv/exec_input.txt
# stall valid instr pc rs1 rs2 | expected result wr_en illegal branch_taken rd (all hex)
# on stall lines the expected columns are unused, the outputs must hold their values
0 1 002081B3 00001000 7FFFFFFF 00000001 80000000 1 0 0 03
0 1 402081B3 00001000 00000005 00000007 FFFFFFFE 1 0 0 03
0 1 0020C1B3 00001000 F0F0F0F0 FF00FF00 0FF00FF0 1 0 0 03
0 1 0020E1B3 00001000 F0F0F0F0 0F000F00 FFF0FFF0 1 0 0 03
0 1 0020F1B3 00001000 F0F0F0F0 FF00FF00 F000F000 1 0 0 03
1 1 002081B3 00001000 11111111 22222222 00000000 0 0 0 00
1 0 00000000 00000000 00000000 00000000 00000000 0 0 0 00
0 1 002091B3 00001000 00000001 0000001F 80000000 1 0 0 03
0 1 002091B3 00001000 12345678 00000020 12345678 1 0 0 03
0 1 0020D1B3 00001000 F0000000 00000001 78000000 1 0 0 03
0 1 0020D1B3 00001000 80000000 0000001F 00000001 1 0 0 03
0 1 4020D1B3 00001000 80000000 0000001F FFFFFFFF 1 0 0 03
0 1 4020D1B3 00001000 F0000000 00000024 FF000000 1 0 0 03
0 1 0020A1B3 00001000 80000000 00000001 00000001 1 0 0 03
0 1 0020B1B3 00001000 80000000 00000001 00000000 1 0 0 03
0 1 FFF08293 00001000 00000005 00000000 00000004 1 0 0 05
0 1 7FF08293 00001000 7FFFFFFF 00000000 800007FE 1 0 0 05
0 1 FFF0C293 00001000 0F0F0F0F 00000000 F0F0F0F0 1 0 0 05
0 1 0F00E293 00001000 12345600 00000000 123456F0 1 0 0 05
0 1 8000F293 00001000 12345FFF 00000000 12345800 1 0 0 05
0 1 0010A293 00001000 80000000 00000000 00000001 1 0 0 05
0 1 FFF0B293 00001000 00000005 00000000 00000001 1 0 0 05
0 1 01F09293 00001000 00000003 00000000 80000000 1 0 0 05
0 1 0010D293 00001000 80000001 00000000 40000000 1 0 0 05
0 1 4040D293 00001000 80000010 00000000 F8000001 1 0 0 05
0 1 ABCDE3B7 00001000 00000000 00000000 ABCDE000 1 0 0 07
0 1 12345037 00001000 00000000 00000000 12345000 0 0 0 00
0 1 FFFFF417 00002000 00000000 00000000 00001000 1 0 0 08
0 1 FE208CE3 00000100 00000003 00000003 000000F8 0 0 1 19
1 1 00209863 00000200 00000055 00000055 00000000 0 0 0 00
0 1 00208863 00000200 00000055 00000056 00000210 0 0 0 10
0 1 00209863 00000200 00000055 00000056 00000210 0 0 1 10
0 1 00209863 00000200 00000055 00000055 00000210 0 0 0 10
0 1 0020C863 00000200 FFFFFFFF 00000001 00000210 0 0 1 10
0 1 0020C863 00000200 00000001 FFFFFFFF 00000210 0 0 0 10
0 1 0020D863 00000200 00000001 FFFFFFFF 00000210 0 0 1 10
0 1 0020D863 00000200 80000000 00000000 00000210 0 0 0 10
0 1 0020E863 00000200 00000001 FFFFFFFF 00000210 0 0 1 10
0 1 0020E863 00000200 FFFFFFFF 00000001 00000210 0 0 0 10
0 1 0020F863 00000200 FFFFFFFF 00000001 00000210 0 0 1 10
0 1 0020F863 00000200 00000001 80000000 00000210 0 0 0 10
0 0 002081B3 00001000 00000001 00000001 00000002 0 0 0 03
0 0 00208863 00000200 00000007 00000007 00000210 0 0 0 10
0 1 0000A183 00001000 00000001 00000002 00000000 0 1 0 03
0 1 0020A863 00000200 00000001 00000001 00000000 0 1 0 10
0 1 002081B3 00001000 00000001 00000002 00000003 1 0 0 03

//--- list.f
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/rv_alu_if.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_exec_stage.sv
dv/tb_rv_exec.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module tb_rv_exec
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_exec > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation PASSED"
exit 0
